// ==== include/mif_mc_params.svh ====
`ifndef MIF_MC_PARAMS_SVH
`define MIF_MC_PARAMS_SVH

// Number of independent memory controller lanes
`define MC_PORTS 4

// Return control travels with a request and comes back on its response
`define RTNCTL_W 32

// Transaction id from the memory interface
`define TID_W 32

// Data word on both sides
`define DATA_W 64

// Virtual address
`define VADR_W 48

// Data word sent in place of the request data for an exchange atomic.
// Only the top bit is set
`define ATOMIC_EXCH_DATA 64'h8000_0000_0000_0000

`endif

// ==== design/mif_mc_pkg.sv ====
`include "mif_mc_params.svh"

package mif_mc_pkg;

	// Quad-word index inside a 64-byte read
	localparam int QW_IDX_W = 3;

	typedef logic [`TID_W-1:0]    tid_t;
	typedef logic [`VADR_W-1:0]   vadr_t;
	typedef logic [`DATA_W-1:0]   data_t;
	typedef logic [`RTNCTL_W-1:0] rtnctl_t;
	typedef logic [QW_IDX_W-1:0]  qw_idx_t;
	typedef logic [3:0]           mc_scmd_t;

	// Request kind as coded by the memory interface
	typedef enum logic [1:0] {
		KIND_READ        = 2'd0,
		KIND_WRITE       = 2'd1,
		KIND_ATOMIC      = 2'd2,
		KIND_ATOMIC_EXCH = 2'd3
	} req_kind_e;

	// Controller request commands
	typedef enum logic [2:0] {
		AEMC_CMD_RD8    = 3'd1,
		AEMC_CMD_WR8    = 3'd2,
		AEMC_CMD_RD64   = 3'd3,
		AEMC_CMD_ATOMIC = 3'd5,
		AEMC_CMD_WR64   = 3'd6
	} mc_rq_cmd_e;

	// Controller response commands
	// Codes not listed here stay unclassified
	typedef enum logic [2:0] {
		MCAE_CMD_RD8_DATA    = 3'd2,
		MCAE_CMD_WR_CMP      = 3'd3,
		MCAE_CMD_ATOMIC_DATA = 3'd4,
		MCAE_CMD_RD64_DATA   = 3'd6,
		MCAE_CMD_WR64_CMP    = 3'd7
	} mc_rs_cmd_e;

	localparam mc_scmd_t AEMC_SCMD_ATOM_EXCH = 4'd2;

	// 149-bit memory-interface request word
	typedef struct packed {
		logic [1:0] size;
		logic       host;
		req_kind_e  kind;
		tid_t       tid;
		vadr_t      vadr;
		data_t      data;
	} mif_req_t;

	// 96-bit read response back to the memory interface
	typedef struct packed {
		logic [`RTNCTL_W-QW_IDX_W-1:0] rtnctl_hi;
		qw_idx_t                       qw_idx;
		data_t                         data;
	} mif_rd_rsp_t;

	// 153-bit controller request
	typedef struct packed {
		rtnctl_t    rtnctl;
		data_t      data;
		vadr_t      vadr;
		logic [1:0] size;
		mc_rq_cmd_e cmd;
		mc_scmd_t   scmd;
	} mc_rq_t;

	// 103-bit controller response
	typedef struct packed {
		mc_rs_cmd_e cmd;
		mc_scmd_t   scmd;
		data_t      data;
		rtnctl_t    rtnctl;
	} mc_rs_t;

endpackage

// ==== design/mc_req_encoder.sv ====
`include "mif_mc_params.svh"

module mc_req_encoder
	import mif_mc_pkg::*;
(
	input  logic     clk,
	input  logic     i_rst_n,

	// Memory-interface side
	input  mif_req_t i_req,
	input  logic     i_req_rdy,
	output logic     o_req_full,

	// Controller side
	output mc_rq_t   o_mc_rq,
	output logic     o_mc_rq_vld,
	input  logic     i_mc_rq_stall
);

	logic [2:0] tid_lo;
	logic       is_single;
	logic [2:0] wr64_scmd;
	mc_rq_cmd_e rq_cmd;
	mc_scmd_t   rq_scmd;
	data_t      rq_data;

	// Low id bits pick between a single word and a 64-byte access
	assign tid_lo    = i_req.tid[2:0];
	assign is_single = (tid_lo == 3'd0);

	// Wraps modulo 8 so low bits 7 give 0
	assign wr64_scmd = tid_lo + 3'd1;

	always_comb begin
		case (i_req.kind)
			KIND_READ: begin
				if (is_single) begin
					rq_cmd = AEMC_CMD_RD8;
				end else begin
					rq_cmd = AEMC_CMD_RD64;
				end
			end
			KIND_WRITE: begin
				if (is_single) begin
					rq_cmd = AEMC_CMD_WR8;
				end else begin
					rq_cmd = AEMC_CMD_WR64;
				end
			end
			default: begin
				rq_cmd = AEMC_CMD_ATOMIC;
			end
		endcase
	end

	always_comb begin
		case (rq_cmd)
			AEMC_CMD_WR64: begin
				rq_scmd = {1'b0, wr64_scmd};
			end
			AEMC_CMD_ATOMIC: begin
				rq_scmd = AEMC_SCMD_ATOM_EXCH;
			end
			default: begin
				rq_scmd = '0;
			end
		endcase
	end

	// Exchange atomic carries a fixed operand
	always_comb begin
		if (i_req.kind == KIND_ATOMIC_EXCH) begin
			rq_data = `ATOMIC_EXCH_DATA;
		end else begin
			rq_data = i_req.data;
		end
	end

	always_comb begin
		o_mc_rq.rtnctl = i_req.tid;
		o_mc_rq.data   = rq_data;
		o_mc_rq.vadr   = i_req.vadr;
		o_mc_rq.size   = i_req.size;
		o_mc_rq.cmd    = rq_cmd;
		o_mc_rq.scmd   = rq_scmd;
	end

	// Valid and stall pass straight across
	assign o_mc_rq_vld = i_req_rdy;
	assign o_req_full  = i_mc_rq_stall;

	property p_cmd_legal;
		@(posedge clk) disable iff (!i_rst_n)
		o_mc_rq_vld |-> o_mc_rq.cmd inside {AEMC_CMD_RD8, AEMC_CMD_WR8,
			AEMC_CMD_RD64, AEMC_CMD_ATOMIC, AEMC_CMD_WR64};
	endproperty

	a_cmd_legal: assert property (p_cmd_legal)
		else $error("illegal controller command %0d sent", o_mc_rq.cmd);

endmodule

// ==== design/mc_rsp_decoder.sv ====
module mc_rsp_decoder
	import mif_mc_pkg::*;
(
	input  logic        clk,
	input  logic        i_rst_n,

	// Controller side
	input  mc_rs_t      i_mc_rs,
	input  logic        i_mc_rs_vld,
	output logic        o_mc_rs_stall,

	// Memory-interface side
	input  logic        i_rd_full,
	input  logic        i_wr_full,
	output mif_rd_rsp_t o_rd_rsp,
	output logic        o_rd_rsp_rdy,
	output logic        o_wr_rsp_rdy,
	output rtnctl_t     o_wr_rsp_tid
);

	logic    is_rd_cmd;
	logic    is_wr_cmd;
	qw_idx_t qw_idx;

	// Atomics return data and so count as reads
	always_comb begin
		case (i_mc_rs.cmd)
			MCAE_CMD_RD8_DATA,
			MCAE_CMD_RD64_DATA,
			MCAE_CMD_ATOMIC_DATA: begin
				is_rd_cmd = 1'b1;
				is_wr_cmd = 1'b0;
			end
			MCAE_CMD_WR_CMP,
			MCAE_CMD_WR64_CMP: begin
				is_rd_cmd = 1'b0;
				is_wr_cmd = 1'b1;
			end
			default: begin
				is_rd_cmd = 1'b0;
				is_wr_cmd = 1'b0;
			end
		endcase
	end

	// Quad-word index only means something for 64-byte reads
	always_comb begin
		if (i_mc_rs.cmd == MCAE_CMD_RD64_DATA) begin
			qw_idx = i_mc_rs.scmd[QW_IDX_W-1:0];
		end else begin
			qw_idx = '0;
		end
	end

	assign o_rd_rsp_rdy = i_mc_rs_vld & is_rd_cmd;
	assign o_wr_rsp_rdy = i_mc_rs_vld & is_wr_cmd;

	// Low id bits are replaced by the quad-word index
	always_comb begin
		o_rd_rsp.rtnctl_hi = i_mc_rs.rtnctl[$bits(rtnctl_t)-1:QW_IDX_W];
		o_rd_rsp.qw_idx    = qw_idx;
		o_rd_rsp.data      = i_mc_rs.data;
	end

	assign o_wr_rsp_tid = i_mc_rs.rtnctl;

	// Either full level holds off the controller
	assign o_mc_rs_stall = i_rd_full | i_wr_full;

	property p_rsp_onehot;
		@(posedge clk) disable iff (!i_rst_n)
		!(o_rd_rsp_rdy && o_wr_rsp_rdy);
	endproperty

	a_rsp_onehot: assert property (p_rsp_onehot)
		else $error("read and write response ready together, cmd %0d", i_mc_rs.cmd);

endmodule

// ==== design/mif_mc_bridge.sv ====
`include "mif_mc_params.svh"

module mif_mc_bridge
	import mif_mc_pkg::*;
(
	input  logic                 clk,
	input  logic                 i_rst_n,

	// Memory-interface side
	input  mif_req_t             i_mif_req        [`MC_PORTS],
	input  logic [`MC_PORTS-1:0] i_mif_req_rdy,
	input  logic [`MC_PORTS-1:0] i_mif_rd_full,
	input  logic [`MC_PORTS-1:0] i_mif_wr_full,
	output logic [`MC_PORTS-1:0] o_mif_req_full,
	output mif_rd_rsp_t          o_mif_rd_rsp     [`MC_PORTS],
	output logic [`MC_PORTS-1:0] o_mif_rd_rsp_rdy,
	output logic [`MC_PORTS-1:0] o_mif_wr_rsp_rdy,
	output rtnctl_t              o_mif_wr_rsp_tid [`MC_PORTS],

	// Controller side
	output mc_rq_t               o_mc_rq          [`MC_PORTS],
	output logic [`MC_PORTS-1:0] o_mc_rq_vld,
	input  logic [`MC_PORTS-1:0] i_mc_rq_stall,
	input  mc_rs_t               i_mc_rs          [`MC_PORTS],
	input  logic [`MC_PORTS-1:0] i_mc_rs_vld,
	output logic [`MC_PORTS-1:0] o_mc_rs_stall
);

	// One request encoder and one response decoder per lane
	genvar n;
	generate
		for (n = 0; n < `MC_PORTS; n = n + 1) begin : g_lane
			mc_req_encoder i_mc_req_encoder (
				.clk           (clk),
				.i_rst_n       (i_rst_n),
				.i_req         (i_mif_req[n]),
				.i_req_rdy     (i_mif_req_rdy[n]),
				.o_req_full    (o_mif_req_full[n]),
				.o_mc_rq       (o_mc_rq[n]),
				.o_mc_rq_vld   (o_mc_rq_vld[n]),
				.i_mc_rq_stall (i_mc_rq_stall[n])
			);

			mc_rsp_decoder i_mc_rsp_decoder (
				.clk           (clk),
				.i_rst_n       (i_rst_n),
				.i_mc_rs       (i_mc_rs[n]),
				.i_mc_rs_vld   (i_mc_rs_vld[n]),
				.o_mc_rs_stall (o_mc_rs_stall[n]),
				.i_rd_full     (i_mif_rd_full[n]),
				.i_wr_full     (i_mif_wr_full[n]),
				.o_rd_rsp      (o_mif_rd_rsp[n]),
				.o_rd_rsp_rdy  (o_mif_rd_rsp_rdy[n]),
				.o_wr_rsp_rdy  (o_mif_wr_rsp_rdy[n]),
				.o_wr_rsp_tid  (o_mif_wr_rsp_tid[n])
			);
		end
	endgenerate

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen (
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	// 40 ns period
	initial begin
		o_clk = 1'b0;
		forever begin
			#20 o_clk = ~o_clk;
		end
	end

endmodule

// ==== tb/tb_mif_mc_bridge.sv ====
`include "mif_mc_params.svh"

module tb_mif_mc_bridge
	import mif_mc_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	typedef logic [$clog2(`MC_PORTS)-1:0] lane_t;

	// All outputs of one lane as one word
	typedef struct packed {
		mc_rq_t      rq;
		logic        rq_vld;
		logic        req_full;
		mif_rd_rsp_t rd_rsp;
		logic        rd_rdy;
		logic        wr_rdy;
		rtnctl_t     wr_tid;
		logic        rs_stall;
	} lane_out_t;

	typedef struct packed {
		lane_t     lane;
		mif_req_t  req;
		logic      req_rdy;
		logic      rq_stall;
		mc_rs_t    rs;
		logic      rs_vld;
		logic      rd_full;
		logic      wr_full;
		lane_out_t exp;
	} test_t;

	logic                 clk;
	logic                 i_rst_n;
	mif_req_t             mif_req        [`MC_PORTS];
	logic [`MC_PORTS-1:0] mif_req_rdy;
	logic [`MC_PORTS-1:0] mif_rd_full;
	logic [`MC_PORTS-1:0] mif_wr_full;
	logic [`MC_PORTS-1:0] mif_req_full;
	mif_rd_rsp_t          mif_rd_rsp     [`MC_PORTS];
	logic [`MC_PORTS-1:0] mif_rd_rsp_rdy;
	logic [`MC_PORTS-1:0] mif_wr_rsp_rdy;
	rtnctl_t              mif_wr_rsp_tid [`MC_PORTS];
	mc_rq_t               mc_rq          [`MC_PORTS];
	logic [`MC_PORTS-1:0] mc_rq_vld;
	logic [`MC_PORTS-1:0] mc_rq_stall;
	mc_rs_t               mc_rs          [`MC_PORTS];
	logic [`MC_PORTS-1:0] mc_rs_vld;
	logic [`MC_PORTS-1:0] mc_rs_stall;

	test_t     tests[$];
	string     names[$];
	lane_out_t idle_out;
	int        seed;
	int        limit;
	int        cycles;
	int        pass_cnt;
	int        fail_cnt;

	tb_clk_gen i_tb_clk_gen (.o_clk(clk));

	mif_mc_bridge i_mif_mc_bridge (
		.clk              (clk),
		.i_rst_n          (i_rst_n),
		.i_mif_req        (mif_req),
		.i_mif_req_rdy    (mif_req_rdy),
		.i_mif_rd_full    (mif_rd_full),
		.i_mif_wr_full    (mif_wr_full),
		.o_mif_req_full   (mif_req_full),
		.o_mif_rd_rsp     (mif_rd_rsp),
		.o_mif_rd_rsp_rdy (mif_rd_rsp_rdy),
		.o_mif_wr_rsp_rdy (mif_wr_rsp_rdy),
		.o_mif_wr_rsp_tid (mif_wr_rsp_tid),
		.o_mc_rq          (mc_rq),
		.o_mc_rq_vld      (mc_rq_vld),
		.i_mc_rq_stall    (mc_rq_stall),
		.i_mc_rs          (mc_rs),
		.i_mc_rs_vld      (mc_rs_vld),
		.o_mc_rs_stall    (mc_rs_stall)
	);

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	function automatic test_t blank(lane_t lane);
		test_t t;
		t = '0;
		t.lane = lane;
		t.exp = idle_out;
		return t;
	endfunction

	task automatic add_req(string name, lane_t lane, req_kind_e kind, logic [2:0] tid_lo,
		logic rdy, mc_rq_cmd_e cmd, mc_scmd_t scmd, logic exch);
		test_t       t;
		logic [63:0] r;
		t = blank(lane);
		r = rand64();
		t.req.tid = {r[31:3], tid_lo};
		t.req.size = r[33:32];
		t.req.host = r[34];
		t.req.kind = kind;
		r = rand64();
		t.req.vadr = r[`VADR_W-1:0];
		t.req.data = rand64();
		t.req_rdy = rdy;
		t.exp.rq.rtnctl = t.req.tid;
		t.exp.rq.data = exch ? `ATOMIC_EXCH_DATA : t.req.data;
		t.exp.rq.vadr = t.req.vadr;
		t.exp.rq.size = t.req.size;
		t.exp.rq.cmd = cmd;
		t.exp.rq.scmd = scmd;
		t.exp.rq_vld = rdy;
		names.push_back(name);
		tests.push_back(t);
	endtask

	task automatic add_rsp(string name, lane_t lane, mc_rs_cmd_e cmd, logic vld,
		logic rd, logic wr, logic qw);
		test_t       t;
		logic [63:0] r;
		t = blank(lane);
		r = rand64();
		t.rs.cmd = cmd;
		t.rs.scmd = r[3:0];
		t.rs.rtnctl = r[63:32];
		t.rs.data = rand64();
		t.rs_vld = vld;
		t.exp.rd_rsp.rtnctl_hi = t.rs.rtnctl[`RTNCTL_W-1:3];
		t.exp.rd_rsp.qw_idx = qw ? t.rs.scmd[2:0] : 3'd0;
		t.exp.rd_rsp.data = t.rs.data;
		t.exp.rd_rdy = rd;
		t.exp.wr_rdy = wr;
		t.exp.wr_tid = t.rs.rtnctl;
		names.push_back(name);
		tests.push_back(t);
	endtask

	task automatic add_flow(string name, lane_t lane, logic rd_full, logic wr_full,
		logic rq_stall, logic exp_stall);
		test_t t;
		t = blank(lane);
		t.rd_full = rd_full;
		t.wr_full = wr_full;
		t.rq_stall = rq_stall;
		t.exp.rs_stall = exp_stall;
		t.exp.req_full = rq_stall;
		names.push_back(name);
		tests.push_back(t);
	endtask

	task automatic build_table();
		// An all-zero request decodes as a single-word read
		idle_out = '0;
		idle_out.rq.cmd = AEMC_CMD_RD8;
		names.push_back("idle_after_reset");
		tests.push_back(blank(2'd0));
		add_req("read_rd8", 2'd0, KIND_READ, 3'd0, 1'b1, AEMC_CMD_RD8, 4'd0, 1'b0);
		add_req("read_rd64", 2'd1, KIND_READ, 3'd5, 1'b1, AEMC_CMD_RD64, 4'd0, 1'b0);
		add_req("read_not_ready", 2'd2, KIND_READ, 3'd0, 1'b0, AEMC_CMD_RD8, 4'd0, 1'b0);
		add_req("write_wr8", 2'd3, KIND_WRITE, 3'd0, 1'b1, AEMC_CMD_WR8, 4'd0, 1'b0);
		add_req("write_wr64", 2'd0, KIND_WRITE, 3'd3, 1'b1, AEMC_CMD_WR64, 4'd4, 1'b0);
		add_req("write_wr64_wrap", 2'd1, KIND_WRITE, 3'd7, 1'b1, AEMC_CMD_WR64, 4'd0, 1'b0);
		add_req("atomic", 2'd2, KIND_ATOMIC, 3'd1, 1'b1, AEMC_CMD_ATOMIC,
			AEMC_SCMD_ATOM_EXCH, 1'b0);
		add_req("atomic_exch", 2'd3, KIND_ATOMIC_EXCH, 3'd6, 1'b1, AEMC_CMD_ATOMIC,
			AEMC_SCMD_ATOM_EXCH, 1'b1);
		for (int l = 0; l < `MC_PORTS; l++) begin
			add_rsp($sformatf("rd8_data_l%0d", l), lane_t'(l), MCAE_CMD_RD8_DATA,
				1'b1, 1'b1, 1'b0, 1'b0);
			add_rsp($sformatf("rd64_data_l%0d", l), lane_t'(l), MCAE_CMD_RD64_DATA,
				1'b1, 1'b1, 1'b0, 1'b1);
			add_rsp($sformatf("atomic_data_l%0d", l), lane_t'(l), MCAE_CMD_ATOMIC_DATA,
				1'b1, 1'b1, 1'b0, 1'b0);
			add_rsp($sformatf("wr_cmp_l%0d", l), lane_t'(l), MCAE_CMD_WR_CMP,
				1'b1, 1'b0, 1'b1, 1'b0);
			add_rsp($sformatf("wr64_cmp_l%0d", l), lane_t'(l), MCAE_CMD_WR64_CMP,
				1'b1, 1'b0, 1'b1, 1'b0);
			add_rsp($sformatf("unclassified_l%0d", l), lane_t'(l), mc_rs_cmd_e'(3'd5),
				1'b1, 1'b0, 1'b0, 1'b0);
			add_rsp($sformatf("rsp_not_valid_l%0d", l), lane_t'(l), MCAE_CMD_RD64_DATA,
				1'b0, 1'b0, 1'b0, 1'b1);
		end
		add_flow("full_none", 2'd0, 1'b0, 1'b0, 1'b0, 1'b0);
		add_flow("full_wr", 2'd1, 1'b0, 1'b1, 1'b1, 1'b1);
		add_flow("full_rd", 2'd2, 1'b1, 1'b0, 1'b0, 1'b1);
		add_flow("full_both", 2'd3, 1'b1, 1'b1, 1'b1, 1'b1);
		add_flow("rq_stall_only", 2'd0, 1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	task automatic idle_inputs();
		mif_req = '{default: '0};
		mc_rs = '{default: '0};
		mif_req_rdy = '0;
		mif_rd_full = '0;
		mif_wr_full = '0;
		mc_rq_stall = '0;
		mc_rs_vld = '0;
	endtask

	function automatic lane_out_t lane_outputs(lane_t ln);
		lane_out_t o;
		o.rq = mc_rq[ln];
		o.rq_vld = mc_rq_vld[ln];
		o.req_full = mif_req_full[ln];
		o.rd_rsp = mif_rd_rsp[ln];
		o.rd_rdy = mif_rd_rsp_rdy[ln];
		o.wr_rdy = mif_wr_rsp_rdy[ln];
		o.wr_tid = mif_wr_rsp_tid[ln];
		o.rs_stall = mc_rs_stall[ln];
		return o;
	endfunction

	task automatic run_test(int k);
		test_t     t;
		lane_out_t exp;
		lane_out_t act;
		logic      ok;
		t = tests[k];
		ok = 1'b1;
		@(posedge clk);
		#2;
		idle_inputs();
		mif_req[t.lane] = t.req;
		mif_req_rdy[t.lane] = t.req_rdy;
		mc_rq_stall[t.lane] = t.rq_stall;
		mc_rs[t.lane] = t.rs;
		mc_rs_vld[t.lane] = t.rs_vld;
		mif_rd_full[t.lane] = t.rd_full;
		mif_wr_full[t.lane] = t.wr_full;
		@(negedge clk);
		// Lanes away from the test must stay idle
		for (int l = 0; l < `MC_PORTS; l++) begin
			exp = (lane_t'(l) == t.lane) ? t.exp : idle_out;
			act = lane_outputs(lane_t'(l));
			assert (act === exp) else begin
				$display("mismatch %s lane %0d expected %h actual %h", names[k], l, exp, act);
				ok = 1'b0;
			end
		end
		if (ok) begin
			pass_cnt++;
			$display("pass %s", names[k]);
		end else begin
			fail_cnt++;
		end
	endtask

	initial begin
		cycles = 0;
		while (limit == 0 || cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the test loop did not finish", cycles);
		$display("Checks failed");
		$finish;
	end

	initial begin
		seed = 32'h989675c1;
		pass_cnt = 0;
		fail_cnt = 0;
		i_rst_n = 1'b0;
		idle_inputs();
		build_table();
		limit = 16 + 2 * tests.size() + 20;
		repeat (16) @(posedge clk);
		#2 i_rst_n = 1'b1;
		foreach (tests[k]) begin
			run_test(k);
		end
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+include
design/mif_mc_pkg.sv
design/mc_req_encoder.sv
design/mc_rsp_decoder.sv
design/mif_mc_bridge.sv
tb/tb_clk_gen.sv
tb/tb_mif_mc_bridge.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_mif_mc_bridge
FILELIST := tb.f
VFLAGS   := --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := All checks passed

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
